/* logic/cart_pkg.sv */
package cart_pkg;

	//////////////////////////////
	// Widths with a meaning
	//////////////////////////////

	typedef logic [15:0] word_t;     // Download or CPU data word
	typedef logic [24:0] dl_addr_t;  // Download byte address
	typedef logic [7:0]  dl_index_t;
	typedef logic [23:1] cpu_addr_t; // CPU word address
	typedef logic [10:0] rom_mask_t; // Covers address bits 23:13
	typedef logic [4:0]  bank_t;     // 512 KB units
	typedef logic [1:0]  region_t;

	typedef enum region_t {
		REGION_JP = 2'd0,
		REGION_US = 2'd1,
		REGION_EU = 2'd2
	} region_code_e;

	//////////////////////////////
	// Bus bundles
	//////////////////////////////

	typedef struct packed {
		logic      download;
		logic      wr;
		dl_index_t index;
		dl_addr_t  addr;
		word_t     data;
	} ioctl_bus_t;

	typedef struct packed {
		logic      page_ce_n; // Mapper register page select
		logic      rnw;
		cpu_addr_t va;
		word_t     vdo;
	} cpu_bus_t;

	typedef struct packed {
		logic       strobe;   // Toggles on every key event
		logic       pressed;
		logic [8:0] code;
	} ps2_key_t;

	// Flags end up in the top 32 bits
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	//////////////////////////////
	// Download indexes and keys
	//////////////////////////////

	localparam logic [5:0] IDX_ROM_MAX       = 6'd1;
	localparam int         IDX_CART_BIT      = 6;
	localparam dl_index_t  IDX_CHEAT         = 8'hFF;
	localparam dl_addr_t   HDR_REGION_ADDR   = 25'h1F0;
	localparam logic [8:0] KEY_F1            = 9'h005;
	localparam logic [8:0] KEY_F2            = 9'h006;
	localparam logic [8:0] KEY_F3            = 9'h004;
	localparam int         NUM_BANKS         = 8;
	localparam logic [3:0] CHEAT_LAST_OFFSET = 4'd14;

endpackage

/* logic/cart_header_sniffer.sv */
`timescale 1ns/1ns

module cart_header_sniffer import cart_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  ioctl_bus_t ioctl,
	output logic       rom_loading,
	output logic       hdr_ready,
	output region_t    hdr_region,
	output rom_mask_t  rom_mask
);

	logic loading_d;
	logic dl_start;
	logic dl_end;
	logic rom_wr;
	logic cart_mode;

	// Index 0 is the BIOS, 1 the cartridge image
	assign rom_loading = ioctl.download & (ioctl.index[5:0] <= IDX_ROM_MAX);
	assign rom_wr      = rom_loading & ioctl.wr;
	assign cart_mode   = ioctl.index[IDX_CART_BIT];

	assign dl_start = rom_loading & ~loading_d;
	assign dl_end   = ~rom_loading & loading_d;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			loading_d <= 1'b0;
		end else begin
			loading_d <= rom_loading;
		end
	end

	//////////////////////////////
	// Region letter in the header
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			hdr_ready  <= 1'b0;
			hdr_region <= REGION_JP;
		end else begin
			if (dl_start) begin
				hdr_ready  <= 1'b0;
				hdr_region <= REGION_JP;
			end
			if (dl_end)
				hdr_ready <= 1'b0;

			if (rom_wr && ioctl.addr == HDR_REGION_ADDR) begin
				if (ioctl.data[7:0] == "J")
					hdr_region <= REGION_JP;
				else if (ioctl.data[7:0] == "U")
					hdr_region <= REGION_US;
				else
					hdr_region <= REGION_EU; // Any other letter
				hdr_ready <= 1'b1;
			end
		end
	end

	//////////////////////////////
	// ROM size mask
	//////////////////////////////

	// Grows with the highest address written, kept after the download
	always_ff @(posedge clk_sys) begin
		if (rom_wr && cart_mode) begin
			if (ioctl.addr == '0)
				rom_mask <= '0; // New image
			else
				rom_mask <= rom_mask | ioctl.addr[23:13];
		end
	end

endmodule

/* logic/region_select.sv */
`timescale 1ns/1ns

module region_select import cart_pkg::*; (
	input  logic     clk_sys,
	input  logic     reset,
	input  ps2_key_t ps2_key,
	input  logic     hdr_ready,
	input  region_t  hdr_region,
	output region_t  region_req,
	output logic     region_set
);

	logic strobe_d;
	logic ready_d;
	logic key_event;
	logic ready_rise;
	logic ready_fall;

	assign key_event  = ps2_key.strobe ^ strobe_d;
	assign ready_rise = hdr_ready & ~ready_d;
	assign ready_fall = ~hdr_ready & ready_d;

	// Previous levels for edge detection
	always_ff @(posedge clk_sys) begin
		strobe_d <= ps2_key.strobe;
		ready_d  <= hdr_ready;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			region_req <= REGION_JP;
			region_set <= 1'b0;
		end else begin
			if (key_event) begin
				case (ps2_key.code)
					KEY_F1: begin
						region_req <= REGION_JP;
						region_set <= ps2_key.pressed;
					end
					KEY_F2: begin
						region_req <= REGION_US;
						region_set <= ps2_key.pressed;
					end
					KEY_F3: begin
						region_req <= REGION_EU;
						region_set <= ps2_key.pressed;
					end
					default: ; // Other keys ignored
				endcase
			end

			// Header result wins over a key in the same cycle
			if (ready_rise) begin
				region_req <= hdr_region;
				region_set <= 1'b1;
			end
			if (ready_fall)
				region_set <= 1'b0;
		end
	end

endmodule

/* logic/bank_mapper.sv */
`timescale 1ns/1ns

module bank_mapper import cart_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	input  cpu_bus_t  cpu,
	input  logic      rom_loading,
	input  rom_mask_t rom_mask,
	output cpu_addr_t rom_addr
);

	bank_t     banks [NUM_BANKS];
	logic      page_ce_d;
	logic      page_fall;
	logic      big_rom;
	logic      bank_wr;
	logic [2:0] reg_sel;
	bank_t     bank_sel;
	cpu_addr_t banked_addr;

	assign page_fall = page_ce_d & ~cpu.page_ce_n;
	assign big_rom   = |rom_mask[10:9]; // Larger than 4 MB
	assign reg_sel   = cpu.va[3:1];

	// Register 0 is fixed, it maps the vector table
	assign bank_wr = page_fall & ~cpu.rnw & (reg_sel != 3'd0) & big_rom;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			page_ce_d <= 1'b1;
		end else begin
			page_ce_d <= cpu.page_ce_n;
		end
	end

	//////////////////////////////
	// Bank registers
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset || rom_loading) begin
			for (int i = 0; i < NUM_BANKS; i++)
				banks[i] <= bank_t'(i); // Identity map
		end else if (bank_wr) begin
			banks[reg_sel] <= cpu.vdo[4:0];
		end
	end

	//////////////////////////////
	// Address translation
	//////////////////////////////

	// Each 512 KB window of the CPU space picks a bank
	assign bank_sel    = banks[cpu.va[21:19]];
	assign banked_addr = {bank_sel, cpu.va[18:1]};

	// Wrap inside the loaded image
	assign rom_addr = banked_addr & {rom_mask, 12'hFFF};

endmodule

/* logic/cheat_code_loader.sv */
`timescale 1ns/1ns

module cheat_code_loader import cart_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  ioctl_bus_t  ioctl,
	output cheat_code_t cheat_code,
	output logic        cheat_strobe_md,
	output logic        cheat_strobe_cd,
	output logic        cheat_reset
);

	logic       cheat_wr;
	logic [3:0] offset;
	logic       last_word;

	assign cheat_wr  = ioctl.download & (ioctl.index == IDX_CHEAT) & ioctl.wr;
	assign offset    = ioctl.addr[3:0]; // Byte offset in a 16 byte code
	assign last_word = cheat_wr & (offset == CHEAT_LAST_OFFSET);

	//////////////////////////////
	// Code assembly
	//////////////////////////////

	// Low half word of each field comes first
	always_ff @(posedge clk_sys) begin
		if (cheat_wr) begin
			case (offset)
				4'd0:  cheat_code.flags[15:0]    <= ioctl.data;
				4'd2:  cheat_code.flags[31:16]   <= ioctl.data;
				4'd4:  cheat_code.address[15:0]  <= ioctl.data;
				4'd6:  cheat_code.address[31:16] <= ioctl.data;
				4'd8:  cheat_code.compare[15:0]  <= ioctl.data;
				4'd10: cheat_code.compare[31:16] <= ioctl.data;
				4'd12: cheat_code.replace[15:0]  <= ioctl.data;
				CHEAT_LAST_OFFSET: cheat_code.replace[31:16] <= ioctl.data;
				default: ;
			endcase
		end
	end

	//////////////////////////////
	// Strobes
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cheat_strobe_md <= 1'b0;
			cheat_strobe_cd <= 1'b0;
			cheat_reset     <= 1'b0;
		end else begin
			// Address bit 31 selects the CD side
			cheat_strobe_md <= last_word & ~cheat_code.address[31];
			cheat_strobe_cd <= last_word & cheat_code.address[31];
			cheat_reset     <= cheat_wr & (ioctl.addr == '0); // New cheat file
		end
	end

endmodule

/* logic/cart_loader_top.sv */
`timescale 1ns/1ns

module cart_loader_top import cart_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,

	input  ioctl_bus_t  ioctl,
	input  cpu_bus_t    cpu,
	input  ps2_key_t    ps2_key,

	output region_t     region_req,
	output logic        region_set,
	output cpu_addr_t   rom_addr,
	output logic        rom_loading,

	output cheat_code_t cheat_code,
	output logic        cheat_strobe_md,
	output logic        cheat_strobe_cd,
	output logic        cheat_reset
);

	logic      hdr_ready;
	region_t   hdr_region;
	rom_mask_t rom_mask;

	cart_header_sniffer sniffer_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.ioctl       (ioctl),
		.rom_loading (rom_loading),
		.hdr_ready   (hdr_ready),
		.hdr_region  (hdr_region),
		.rom_mask    (rom_mask)
	);

	region_select region_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.ps2_key    (ps2_key),
		.hdr_ready  (hdr_ready),
		.hdr_region (hdr_region),
		.region_req (region_req),
		.region_set (region_set)
	);

	bank_mapper mapper_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.cpu         (cpu),
		.rom_loading (rom_loading),
		.rom_mask    (rom_mask),
		.rom_addr    (rom_addr)
	);

	cheat_code_loader cheat_i (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.ioctl           (ioctl),
		.cheat_code      (cheat_code),
		.cheat_strobe_md (cheat_strobe_md),
		.cheat_strobe_cd (cheat_strobe_cd),
		.cheat_reset     (cheat_reset)
	);

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen (
	input  logic reset_req,  // Extra reset pulse from the test sequence
	output logic clk_sys,
	output logic reset
);

	localparam int HALF_PERIOD  = 4; // 8 ns clock
	localparam int RESET_CYCLES = 8;

	logic power_on;

	initial begin
		clk_sys = 1'b0;
		forever #HALF_PERIOD clk_sys = ~clk_sys;
	end

	initial begin
		power_on = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		#1 power_on = 1'b0;
	end

	assign reset = power_on | reset_req;

endmodule

/* tb/tb_cart_loader.sv */
`timescale 1ns/1ns

module tb_cart_loader import cart_pkg::*; ();

	localparam int CYCLE_LIMIT = 3000; // About twice the test length
	localparam int ADDR_CHECKS = 300;
	localparam int MB          = 1 << 20;

	logic        clk_sys;
	logic        reset;
	logic        reset_req;
	ioctl_bus_t  ioctl;
	cpu_bus_t    cpu;
	ps2_key_t    ps2_key;
	region_t     region_req;
	logic        region_set;
	cpu_addr_t   rom_addr;
	logic        rom_loading;
	cheat_code_t cheat_code;
	logic        cheat_strobe_md;
	logic        cheat_strobe_cd;
	logic        cheat_reset;

	integer      seed;
	logic [31:0] rnd;
	string       test_name = "startup";
	int          check_errors = 0;
	int          err_strobe_pair = 0;
	int          err_reset_pulse = 0;
	int          err_strobe_width = 0;
	int          err_loading = 0;
	int          cycle_count = 0;
	bank_t       ref_banks [NUM_BANKS]; // Expected bank registers
	rom_mask_t   ref_mask;
	cheat_code_t code_a;
	cheat_code_t code_b;
	logic        cheat_wr_zero;

	tb_clock_gen clock_gen_i (
		.reset_req (reset_req),
		.clk_sys   (clk_sys),
		.reset     (reset)
	);

	cart_loader_top cart_loader_top_i (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.ioctl           (ioctl),
		.cpu             (cpu),
		.ps2_key         (ps2_key),
		.region_req      (region_req),
		.region_set      (region_set),
		.rom_addr        (rom_addr),
		.rom_loading     (rom_loading),
		.cheat_code      (cheat_code),
		.cheat_strobe_md (cheat_strobe_md),
		.cheat_strobe_cd (cheat_strobe_cd),
		.cheat_reset     (cheat_reset)
	);

	//////////////////////////////
	// Properties
	//////////////////////////////

	assign cheat_wr_zero = ioctl.download && ioctl.index == IDX_CHEAT && ioctl.wr
		&& ioctl.addr == '0;

	assert property (@(posedge clk_sys) disable iff (reset)
		!(cheat_strobe_md && cheat_strobe_cd))
	else begin
		err_strobe_pair++;
		$display("error %s strobe_pair: expected 1 strobe at most, actual md %0b cd %0b",
			test_name, cheat_strobe_md, cheat_strobe_cd);
	end

	assert property (@(posedge clk_sys) disable iff (reset)
		cheat_reset == $past(cheat_wr_zero))
	else begin
		err_reset_pulse++;
		$display("error %s cheat_reset: expected %0b, actual %0b",
			test_name, $past(cheat_wr_zero), cheat_reset);
	end

	assert property (@(posedge clk_sys) disable iff (reset)
		(cheat_strobe_md || cheat_strobe_cd) |=> !(cheat_strobe_md || cheat_strobe_cd))
	else begin
		err_strobe_width++;
		$display("error %s strobe_width: expected 0, actual 1", test_name);
	end

	assert property (@(posedge clk_sys)
		rom_loading == (ioctl.download && ioctl.index[5:0] <= IDX_ROM_MAX))
	else begin
		err_loading++;
		$display("error %s rom_loading: expected %0b, actual %0b", test_name,
			ioctl.download && ioctl.index[5:0] <= IDX_ROM_MAX, rom_loading);
	end

	// Run limit
	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout in %s, run passed %0d cycles", test_name, CYCLE_LIMIT);
			$display("Testbench failed");
			$finish;
		end
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	task automatic tick();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic check_equal(input string what, input logic [127:0] expected,
		input logic [127:0] actual);
		assert (actual == expected)
		else begin
			check_errors++;
			$display("error %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
		end
	endtask

	task automatic set_identity();
		for (int i = 0; i < NUM_BANKS; i++)
			ref_banks[i] = bank_t'(i);
	endtask

	// Bank of the 512 KB window, then the size mask
	function automatic cpu_addr_t expected_rom_addr(input cpu_addr_t va);
		cpu_addr_t banked;
		banked = {ref_banks[va[21:19]], va[18:1]};
		return banked & {ref_mask, 12'hFFF};
	endfunction

	task automatic write_word(input dl_addr_t addr, input word_t data);
		ioctl.addr = addr;
		ioctl.data = data;
		ioctl.wr   = 1'b1;
		tick();
	endtask

	// First word, header word and last word of an image
	task automatic load_rom(input dl_index_t index, input int size_bytes,
		input logic [7:0] letter);
		ioctl.download = 1'b1;
		ioctl.index    = index;
		ioctl.wr       = 1'b0;
		tick();
		check_equal("rom_loading", 128'(1'b1), 128'(rom_loading));
		write_word('0, 16'h4D45);
		write_word(HDR_REGION_ADDR, {8'h20, letter});
		rnd = $random(seed);
		write_word(dl_addr_t'(size_bytes - 2), rnd[15:0]);
		ioctl.wr = 1'b0;
		tick();
		ioctl.download = 1'b0;
		set_identity();
		if (index[IDX_CART_BIT])
			ref_mask = rom_mask_t'((size_bytes - 1) >> 13); // Highest byte address, bits 23:13
	endtask

	task automatic header_case(input logic [7:0] letter, input region_t expected);
		load_rom(8'h41, MB, letter);
		check_equal("region_set high", 128'(1'b1), 128'(region_set));
		check_equal("region_req", 128'(expected), 128'(region_req));
		tick();
		check_equal("region_set held", 128'(1'b1), 128'(region_set));
		tick();
		check_equal("region_set low", 128'(1'b0), 128'(region_set));
	endtask

	task automatic key_event(input logic [8:0] code, input logic pressed,
		input region_t expected_req, input logic expected_set);
		logic prev_set;
		prev_set        = region_set;
		ps2_key.strobe  = ~ps2_key.strobe;
		ps2_key.code    = code;
		ps2_key.pressed = pressed;
		#2;
		check_equal("region_set before edge", 128'(prev_set), 128'(region_set));
		tick();
		check_equal("key region_req", 128'(expected_req), 128'(region_req));
		check_equal("key region_set", 128'(expected_set), 128'(region_set));
	endtask

	task automatic page_write(input logic [2:0] reg_num, input bank_t value);
		cpu.page_ce_n = 1'b0;
		cpu.rnw       = 1'b0;
		cpu.va        = {20'h50987, reg_num};
		cpu.vdo       = {11'h000, value};
		tick();
		cpu.page_ce_n = 1'b1;
		cpu.rnw       = 1'b1;
		tick();
		if (reg_num != 3'd0 && ref_mask[10:9] != 2'b00)
			ref_banks[reg_num] = value; // Only above 4 MB
	endtask

	task automatic random_banks();
		for (int r = 0; r < NUM_BANKS; r++) begin
			rnd = $random(seed);
			page_write(3'(r), rnd[4:0]);
		end
	endtask

	task automatic check_windows(input string what, input int count);
		cpu_addr_t va;
		for (int n = 0; n < count; n++) begin
			rnd    = $random(seed);
			va     = cpu_addr_t'(rnd);
			cpu.va = va;
			#2;
			check_equal(what, 128'(expected_rom_addr(va)), 128'(rom_addr));
			tick();
		end
	endtask

	task automatic send_cheat(input dl_addr_t base, input cheat_code_t code);
		word_t words [8];
		logic  cd_side;
		words[0] = code.flags[15:0];
		words[1] = code.flags[31:16];
		words[2] = code.address[15:0];
		words[3] = code.address[31:16];
		words[4] = code.compare[15:0];
		words[5] = code.compare[31:16];
		words[6] = code.replace[15:0];
		words[7] = code.replace[31:16];
		cd_side  = code.address[31];
		ioctl.download = 1'b1;
		ioctl.index    = IDX_CHEAT;
		for (int k = 0; k < 8; k++) begin
			write_word(base + dl_addr_t'(2 * k), words[k]);
			check_equal("cheat_reset", 128'(base == '0 && k == 0), 128'(cheat_reset));
			check_equal("strobe_md", 128'(k == 7 && !cd_side), 128'(cheat_strobe_md));
			check_equal("strobe_cd", 128'(k == 7 && cd_side), 128'(cheat_strobe_cd));
		end
		ioctl.wr = 1'b0;
		tick();
		check_equal("strobe_md end", 128'(1'b0), 128'(cheat_strobe_md));
		check_equal("strobe_cd end", 128'(1'b0), 128'(cheat_strobe_cd));
		check_equal("cheat_code", 128'(code), 128'(cheat_code));
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial begin
		seed      = 85;
		reset_req = 1'b0;
		ioctl     = '0;
		cpu       = '0;
		cpu.page_ce_n = 1'b1;
		cpu.rnw       = 1'b1;
		ps2_key   = '0;
		ref_mask  = '0;
		set_identity();
		@(negedge reset);
		tick();

		test_name = "header_region";
		header_case("J", REGION_JP);
		header_case("U", REGION_US);
		header_case("X", REGION_EU);
		check_equal("rom_loading after", 128'(1'b0), 128'(rom_loading));

		test_name = "function_keys";
		key_event(KEY_F2, 1'b1, REGION_US, 1'b1);
		key_event(KEY_F2, 1'b0, REGION_US, 1'b0);
		key_event(KEY_F3, 1'b1, REGION_EU, 1'b1);
		key_event(KEY_F3, 1'b0, REGION_EU, 1'b0);
		key_event(KEY_F1, 1'b1, REGION_JP, 1'b1);
		key_event(KEY_F1, 1'b0, REGION_JP, 1'b0);
		key_event(9'h01C, 1'b1, REGION_JP, 1'b0); // Not a region key

		test_name = "size_mask";
		load_rom(8'h41, MB, "J");
		for (int n = 0; n < ADDR_CHECKS; n++) begin
			rnd    = $random(seed);
			cpu.va = cpu_addr_t'(rnd);
			#2;
			check_equal("rom_addr", 128'(cpu.va & cpu_addr_t'((MB / 2) - 1)), 128'(rom_addr));
			tick();
		end

		test_name = "bank_switch";
		load_rom(8'h41, 8 * MB, "U");
		random_banks();
		check_windows("rom_addr 8 MB", ADDR_CHECKS);
		load_rom(8'h41, 2 * MB, "U");
		random_banks();
		check_windows("rom_addr 2 MB", ADDR_CHECKS);

		test_name = "bank_restore";
		load_rom(8'h41, 8 * MB, "X");
		random_banks();
		check_windows("rom_addr switched", 50);
		key_event(KEY_F2, 1'b1, REGION_US, 1'b1); // Raise region_set ahead of reset
		reset_req = 1'b1;
		tick();
		tick();
		reset_req = 1'b0;
		set_identity();
		check_equal("region_set reset", 128'(1'b0), 128'(region_set));
		check_equal("strobe_md reset", 128'(1'b0), 128'(cheat_strobe_md));
		check_equal("strobe_cd reset", 128'(1'b0), 128'(cheat_strobe_cd));
		check_equal("cheat_reset reset", 128'(1'b0), 128'(cheat_reset));
		check_windows("rom_addr after reset", 200);
		random_banks();
		load_rom(8'h41, 8 * MB, "J");
		check_windows("rom_addr after download", 200);

		test_name = "cheat_codes";
		rnd = $random(seed);
		code_a.flags   = rnd;
		rnd = $random(seed);
		code_a.address = {1'b0, rnd[30:0]}; // Main CPU side
		rnd = $random(seed);
		code_a.compare = rnd;
		rnd = $random(seed);
		code_a.replace = rnd;
		rnd = $random(seed);
		code_b.flags   = rnd;
		rnd = $random(seed);
		code_b.address = {1'b1, rnd[30:0]}; // CD CPU side
		rnd = $random(seed);
		code_b.compare = rnd;
		rnd = $random(seed);
		code_b.replace = rnd;
		send_cheat('0, code_a);
		send_cheat(25'h10, code_b);
		ioctl.download = 1'b0;
		tick();

		$display("Errors: %0d in checks, %0d in properties", check_errors,
			err_strobe_pair + err_reset_pulse + err_strobe_width + err_loading);
		if (check_errors + err_strobe_pair + err_reset_pulse + err_strobe_width
			+ err_loading == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

/* cart_loader.f */
logic/cart_pkg.sv
logic/cart_header_sniffer.sv
logic/region_select.sv
logic/bank_mapper.sv
logic/cheat_code_loader.sv
logic/cart_loader_top.sv
tb/tb_clock_gen.sv
tb/tb_cart_loader.sv

/* Makefile */
TOP = tb_cart_loader

.PHONY: sim clean

sim:
	verilator --binary --timing --top-module $(TOP) -f cart_loader.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Testbench passed"

clean:
	rm -rf obj_dir
